//--- Bender.yml
package:
  name: core_bus

sources:
  - include_dirs:
      - .
    files:
      - core_bus_pkg.sv
      - core_bus_read_arbiter.sv
      - core_bus_store.sv
      - core_bus_timer.sv
      - core_bus_resp_router.sv
      - core_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_bus_mem_model.sv
      - core_bus_assertions.sv
      - core_bus_tb.sv

//--- core_bus.sv
`timescale 1ns/10ps

module core_bus (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,

  // fetch
  input  logic                     fetch_valid,
  input  core_bus_pkg::fetch_req_t fetch_req,
  input  logic                     fetch_lock,
  output logic                     fetch_ready,
  output logic                     fetch_rvalid,
  output core_bus_pkg::data_t      fetch_rdata,

  // load
  input  logic                     load_valid,
  input  core_bus_pkg::load_req_t  load_req,
  output logic                     load_rvalid,
  output core_bus_pkg::data_t      load_rdata,

  // store
  input  logic                     store_valid,
  input  core_bus_pkg::store_req_t store_req,
  output logic                     store_done,

  // AXI master
  output logic                     ar_valid,
  output core_bus_pkg::axi_ar_t    ar,
  input  logic                     ar_ready,
  input  logic                     r_valid,
  input  core_bus_pkg::axi_r_t     r,
  output logic                     r_ready,
  output logic                     aw_valid,
  output core_bus_pkg::axi_aw_t    aw,
  input  logic                     aw_ready,
  output logic                     w_valid,
  output core_bus_pkg::axi_w_t     w,
  input  logic                     w_ready,
  input  logic                     b_valid,
  input  core_bus_pkg::axi_b_t     b,
  output logic                     b_ready
);
  import core_bus_pkg::*;

  read_owner_t read_owner;
  logic        timer_req;
  logic        timer_sel_hi;
  logic        timer_rvalid;
  data_t       timer_rdata;

  core_bus_read_arbiter u_read_arbiter (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .fetch_valid  (fetch_valid),
    .fetch_req    (fetch_req),
    .fetch_lock   (fetch_lock),
    .fetch_ready  (fetch_ready),
    .load_valid   (load_valid),
    .load_req     (load_req),
    .ar_valid     (ar_valid),
    .ar           (ar),
    .ar_ready     (ar_ready),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .timer_req    (timer_req),
    .timer_sel_hi (timer_sel_hi),
    .read_owner   (read_owner)
  );

  // write channels run on their own
  core_bus_store u_store (
    .clock       (clock),
    .reset       (reset),
    .store_valid (store_valid),
    .store_req   (store_req),
    .store_done  (store_done),
    .aw_valid    (aw_valid),
    .aw          (aw),
    .aw_ready    (aw_ready),
    .w_valid     (w_valid),
    .w           (w),
    .w_ready     (w_ready),
    .b_valid     (b_valid),
    .b           (b),
    .b_ready     (b_ready)
  );

  core_bus_timer u_timer (
    .clock        (clock),
    .reset        (reset),
    .timer_req    (timer_req),
    .timer_sel_hi (timer_sel_hi),
    .timer_rvalid (timer_rvalid),
    .timer_rdata  (timer_rdata)
  );

  core_bus_resp_router u_resp_router (
    .read_owner   (read_owner),
    .load_req     (load_req),
    .r_valid      (r_valid),
    .r            (r),
    .timer_rvalid (timer_rvalid),
    .timer_rdata  (timer_rdata),
    .fetch_rvalid (fetch_rvalid),
    .fetch_rdata  (fetch_rdata),
    .load_rvalid  (load_rvalid),
    .load_rdata   (load_rdata)
  );

endmodule

//--- core_bus_assertions.sv
`timescale 1ns/10ps
`include "core_bus_settings.svh"

module core_bus_assertions (
  input logic                  clock,
  input logic                  reset,
  input logic                  ar_valid,
  input core_bus_pkg::axi_ar_t ar,
  input logic                  ar_ready,
  input logic                  r_valid,
  input core_bus_pkg::axi_r_t  r,
  input logic                  r_ready,
  input logic                  aw_valid,
  input core_bus_pkg::axi_aw_t aw,
  input logic                  aw_ready,
  input logic                  w_valid,
  input core_bus_pkg::axi_w_t  w,
  input logic                  w_ready,
  input logic                  b_valid,
  input core_bus_pkg::axi_b_t  b,
  input logic                  b_ready,
  input logic                  store_done
);
  import core_bus_pkg::*;

  logic read_open;
  logic w_seen;
  int   fail_count = 0;  // assertion failures so far

  task automatic note_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  always_ff @(posedge clock) begin
    if (reset) begin
      read_open <= 1'b0;
      w_seen <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) read_open <= 1'b1;
      else if (r_valid && r_ready) read_open <= 1'b0;
      if (w_valid && w_ready) w_seen <= 1'b1;
      else if (store_done) w_seen <= 1'b0;
    end
  end

  ar_stable: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else note_failure("AR payload changed");
  aw_stable: assert property (@(posedge clock) disable iff (reset)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else note_failure("AW payload changed");
  w_stable: assert property (@(posedge clock) disable iff (reset)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else note_failure("W payload changed");
  one_read: assert property (@(posedge clock) disable iff (reset)
    ar_valid && ar_ready |-> !read_open)
    else note_failure("second read outstanding");
  r_okay: assert property (@(posedge clock) disable iff (reset)
    r_valid && r_ready |-> r.resp == `CORE_BUS_RESP_OKAY)
    else note_failure("R not OKAY");
  b_okay: assert property (@(posedge clock) disable iff (reset)
    b_valid && b_ready |-> b.resp == `CORE_BUS_RESP_OKAY)
    else note_failure("B not OKAY");
  done_after_w: assert property (@(posedge clock) disable iff (reset)
    store_done |-> w_seen)
    else note_failure("store_done without a W beat");

endmodule

bind core_bus core_bus_assertions checker_inst (
  .clock(clock), .reset(reset),
  .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
  .r_valid(r_valid), .r(r), .r_ready(r_ready),
  .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
  .w_valid(w_valid), .w(w), .w_ready(w_ready),
  .b_valid(b_valid), .b(b), .b_ready(b_ready),
  .store_done(store_done)
);

//--- core_bus_mem_model.sv
`timescale 1ns/10ps
`include "core_bus_settings.svh"

module core_bus_mem_model (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ar_valid,
  input  core_bus_pkg::axi_ar_t ar,
  output logic                  ar_ready,
  output logic                  r_valid,
  output core_bus_pkg::axi_r_t  r,
  input  logic                  r_ready,
  input  logic                  aw_valid,
  input  core_bus_pkg::axi_aw_t aw,
  output logic                  aw_ready,
  input  logic                  w_valid,
  input  core_bus_pkg::axi_w_t  w,
  output logic                  w_ready,
  output logic                  b_valid,
  output core_bus_pkg::axi_b_t  b,
  input  logic                  b_ready
);
  import core_bus_pkg::*;

  data_t      mem [0:255];
  logic [7:0] lfsr;
  logic       r_busy;
  logic [1:0] r_wait;
  addr_t      r_addr;
  logic       aw_taken;
  addr_t      w_addr;

  // 8-bit Fibonacci, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = i * 32'h0101_0101;
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      lfsr = 8'd70;
      ar_ready <= 1'b0;
      r_valid <= 1'b0;
      r <= '0;
      r_busy <= 1'b0;
      r_wait <= 2'd0;
      aw_ready <= 1'b0;
      w_ready <= 1'b0;
      b_valid <= 1'b0;
      b <= '0;
      aw_taken <= 1'b0;
    end else begin
      // read side
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
        r_busy <= 1'b0;
      end else if (r_busy && !r_valid) begin
        if (r_wait == 2'd0) begin
          r_valid <= 1'b1;
          r <= '{data: mem[r_addr[9:2]], resp: `CORE_BUS_RESP_OKAY, last: 1'b1};
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
      if (ar_valid && ar_ready) begin
        r_busy <= 1'b1;
        r_addr <= ar.addr;
        ar_ready <= 1'b0;
        lfsr = lfsr_next(lfsr);
        r_wait[0] <= lfsr[0];
        lfsr = lfsr_next(lfsr);
        r_wait[1] <= lfsr[0];
      end else if (!r_busy) begin
        lfsr = lfsr_next(lfsr);
        ar_ready <= lfsr[0];
      end else begin
        ar_ready <= 1'b0;
      end

      // write side
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
        aw_taken <= 1'b0;
      end
      if (aw_valid && aw_ready) begin
        aw_taken <= 1'b1;
        w_addr <= aw.addr;
        aw_ready <= 1'b0;
      end else if (!aw_taken) begin
        lfsr = lfsr_next(lfsr);
        aw_ready <= lfsr[0];
      end
      if (w_valid && w_ready) begin
        for (int k = 0; k < 4; k++) begin
          if (w.strb[k]) mem[w_addr[9:2]][k*8 +: 8] <= w.data[k*8 +: 8];
        end
        w_ready <= 1'b0;
        b_valid <= 1'b1;
        b <= '{resp: `CORE_BUS_RESP_OKAY};
      end else if (aw_taken && !b_valid) begin
        lfsr = lfsr_next(lfsr);
        w_ready <= lfsr[0];
      end
    end
  end

endmodule

//--- core_bus_pkg.sv
`include "core_bus_settings.svh"

package core_bus_pkg;

  typedef logic [`CORE_BUS_XLEN-1:0] addr_t;
  typedef logic [`CORE_BUS_XLEN-1:0] data_t;
  typedef logic [3:0]                strb_t;
  typedef logic [2:0]                size_t;
  typedef logic [63:0]               mtime_t;

  // core side
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    addr_t addr;
    strb_t strb;  // 1, 3 or f on the low lanes
  } load_req_t;

  typedef struct packed {
    addr_t addr;
    data_t data;  // not yet shifted to its lane
    strb_t strb;
  } store_req_t;

  // AXI side, single beat, id 0
  typedef struct packed {
    addr_t addr;
    size_t size;
  } axi_ar_t;

  typedef struct packed {
    addr_t addr;
    size_t size;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    data_t      data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_WAIT,
    LOAD_WAIT,
    LOAD_FLUSHED,
    TIMER_WAIT
  } read_state_t;

  typedef enum logic [1:0] {
    ADDR,
    DATA,
    RESP
  } store_state_t;

  typedef enum logic [2:0] {
    NONE,
    FETCH,
    LOAD,
    DROP,
    TIMER
  } read_owner_t;

endpackage

//--- core_bus_read_arbiter.sv
`timescale 1ns/10ps
`include "core_bus_settings.svh"

module core_bus_read_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,
  input  logic                     fetch_valid,
  input  core_bus_pkg::fetch_req_t fetch_req,
  input  logic                     fetch_lock,
  output logic                     fetch_ready,
  input  logic                     load_valid,
  input  core_bus_pkg::load_req_t  load_req,
  output logic                     ar_valid,
  output core_bus_pkg::axi_ar_t    ar,
  input  logic                     ar_ready,
  input  logic                     r_valid,
  output logic                     r_ready,
  output logic                     timer_req,
  output logic                     timer_sel_hi,
  output core_bus_pkg::read_owner_t read_owner
);
  import core_bus_pkg::*;

  read_state_t state;
  read_state_t state_next;

  // AR beat offered but not yet taken by the slave
  logic    pend_valid;
  logic    pend_load;
  logic    pend_flush;
  axi_ar_t pend_ar;

  logic    issue_load;
  logic    load_timer;
  logic    load_go;
  logic    load_cancel;
  size_t   load_size;
  axi_ar_t fetch_ar;
  axi_ar_t load_ar;

  assign load_timer = (load_req.addr == `CORE_BUS_MTIME_LO_ADDR) ||
                      (load_req.addr == `CORE_BUS_MTIME_HI_ADDR);
  assign timer_sel_hi = (load_req.addr == `CORE_BUS_MTIME_HI_ADDR);
  assign load_go = load_valid && !fetch_lock && !flush;
  assign load_cancel = flush || (pend_valid && pend_flush);

  always_comb begin
    case (load_req.strb)
      4'h1:    load_size = `CORE_BUS_SIZE_BYTE;
      4'h3:    load_size = `CORE_BUS_SIZE_HALF;
      default: load_size = `CORE_BUS_SIZE_WORD;
    endcase
  end

  assign fetch_ar = '{addr: fetch_req.addr, size: `CORE_BUS_SIZE_WORD};
  assign load_ar = '{addr: load_req.addr, size: load_size};

  // a load waiting on ar_ready keeps the grant over a newer fetch
  assign fetch_ready = (state == IDLE) && !(pend_valid && pend_load);
  assign r_ready = (state == FETCH_WAIT) || (state == LOAD_WAIT) || (state == LOAD_FLUSHED);

  always_comb begin
    state_next = state;
    ar_valid = 1'b0;
    ar = fetch_ar;
    issue_load = 1'b0;
    timer_req = 1'b0;
    case (state)
      IDLE: begin
        if (pend_valid) begin
          ar_valid = 1'b1;
          ar = pend_ar;
          issue_load = pend_load;
        end else if (fetch_valid) begin  // fetch wins
          ar_valid = 1'b1;
        end else if (load_go && load_timer) begin
          timer_req = 1'b1;
          state_next = TIMER_WAIT;
        end else if (load_go) begin
          ar_valid = 1'b1;
          ar = load_ar;
          issue_load = 1'b1;
        end
        if (ar_valid && ar_ready) begin
          if (!issue_load) begin
            state_next = FETCH_WAIT;
          end else if (load_cancel) begin
            state_next = LOAD_FLUSHED;
          end else begin
            state_next = LOAD_WAIT;
          end
        end
      end
      FETCH_WAIT: if (r_valid) state_next = IDLE;
      LOAD_WAIT: begin
        if (r_valid) begin
          state_next = IDLE;
        end else if (flush) begin
          state_next = LOAD_FLUSHED;
        end
      end
      LOAD_FLUSHED: if (r_valid) state_next = IDLE;
      TIMER_WAIT: state_next = IDLE;  // timer always answers next cycle
      default: state_next = IDLE;
    endcase
  end

  always_comb begin
    case (state)
      FETCH_WAIT:   read_owner = FETCH;
      LOAD_WAIT:    read_owner = flush ? DROP : LOAD;
      LOAD_FLUSHED: read_owner = DROP;
      TIMER_WAIT:   read_owner = flush ? DROP : TIMER;
      default:      read_owner = NONE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      pend_valid <= 1'b0;
      pend_flush <= 1'b0;
    end else begin
      state <= state_next;
      pend_valid <= ar_valid && !ar_ready;
      pend_flush <= ar_valid && !ar_ready && issue_load && load_cancel;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_valid) begin
      pend_ar <= ar;
      pend_load <= issue_load;
    end
  end

endmodule

//--- core_bus_resp_router.sv
`timescale 1ns/10ps

module core_bus_resp_router (
  input  core_bus_pkg::read_owner_t read_owner,
  input  core_bus_pkg::load_req_t   load_req,
  input  logic                      r_valid,
  input  core_bus_pkg::axi_r_t      r,
  input  logic                      timer_rvalid,
  input  core_bus_pkg::data_t       timer_rdata,
  output logic                      fetch_rvalid,
  output core_bus_pkg::data_t       fetch_rdata,
  output logic                      load_rvalid,
  output core_bus_pkg::data_t       load_rdata
);
  import core_bus_pkg::*;

  logic [1:0] offset;
  logic       mem_hit;
  logic       timer_hit;
  data_t      raw_data;
  data_t      shifted;
  data_t      byte_mask;

  // single beat reads, every R beat is the last one
  assign fetch_rvalid = (read_owner == FETCH) && r_valid && r.last;
  assign fetch_rdata = r.data;

  assign mem_hit = (read_owner == LOAD) && r_valid && r.last;
  assign timer_hit = (read_owner == TIMER) && timer_rvalid;
  assign load_rvalid = mem_hit || timer_hit;  // DROP swallows the beat

  assign raw_data = (read_owner == TIMER) ? timer_rdata : r.data;

  // bring the addressed lane down to lane 0
  assign offset = load_req.addr[1:0];
  assign shifted = raw_data >> {offset, 3'b000};

  assign byte_mask = {
    {8{load_req.strb[3]}},
    {8{load_req.strb[2]}},
    {8{load_req.strb[1]}},
    {8{load_req.strb[0]}}
  };

  assign load_rdata = shifted & byte_mask;

endmodule

//--- core_bus_settings.svh
`ifndef CORE_BUS_SETTINGS_SVH
`define CORE_BUS_SETTINGS_SVH

// data and address width
`define CORE_BUS_XLEN 32

// core-local timer, served without an AXI transaction
`define CORE_BUS_MTIME_LO_ADDR 32'h0200_BFF8
`define CORE_BUS_MTIME_HI_ADDR 32'h0200_BFFC

// AXI size encodings for byte, halfword and word transfers
`define CORE_BUS_SIZE_BYTE 3'b000
`define CORE_BUS_SIZE_HALF 3'b001
`define CORE_BUS_SIZE_WORD 3'b010

// AXI response codes
`define CORE_BUS_RESP_OKAY 2'b00

`endif

//--- core_bus_store.sv
`timescale 1ns/10ps
`include "core_bus_settings.svh"

module core_bus_store (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     store_valid,
  input  core_bus_pkg::store_req_t store_req,
  output logic                     store_done,
  output logic                     aw_valid,
  output core_bus_pkg::axi_aw_t    aw,
  input  logic                     aw_ready,
  output logic                     w_valid,
  output core_bus_pkg::axi_w_t     w,
  input  logic                     w_ready,
  input  logic                     b_valid,
  input  core_bus_pkg::axi_b_t     b,
  output logic                     b_ready
);
  import core_bus_pkg::*;

  store_state_t state;
  store_state_t state_next;

  logic [1:0] offset;
  size_t      store_size;
  data_t      lane_data;
  strb_t      lane_strb;

  assign offset = store_req.addr[1:0];

  always_comb begin
    case (store_req.strb)
      4'h1:    store_size = `CORE_BUS_SIZE_BYTE;
      4'h3:    store_size = `CORE_BUS_SIZE_HALF;
      default: store_size = `CORE_BUS_SIZE_WORD;
    endcase
  end

  // move data and strobe up to the addressed lanes
  assign lane_data = store_req.data << {offset, 3'b000};
  assign lane_strb = store_req.strb << offset;

  assign aw = '{addr: store_req.addr, size: store_size};
  assign w = '{data: lane_data, strb: lane_strb, last: 1'b1};  // single beat

  assign aw_valid = (state == ADDR) && store_valid;
  assign w_valid = (state == DATA);
  assign b_ready = (state == RESP);

  // the store completes whatever the B response
  assign store_done = (state == RESP) && b_valid;

  always_comb begin
    state_next = state;
    case (state)
      ADDR: begin
        if (aw_valid && aw_ready) begin
          state_next = DATA;
        end
      end
      DATA: begin
        if (w_ready) begin
          state_next = RESP;
        end
      end
      RESP: begin
        if (b_valid) begin
          state_next = ADDR;
        end
      end
      default: state_next = ADDR;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ADDR;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- core_bus_tb.sv
`timescale 1ns/10ps
`include "core_bus_settings.svh"

module core_bus_tb;
  import core_bus_pkg::*;

  localparam int TIMEOUT = 200;
  localparam logic [2:0] K_FETCH = 3'd0;
  localparam logic [2:0] K_LOAD  = 3'd1;
  localparam logic [2:0] K_STORE = 3'd2;
  localparam logic [2:0] K_FLUSH = 3'd3;
  localparam logic [2:0] K_TIMER = 3'd4;
  localparam logic [2:0] K_BOTH  = 3'd5;  // data holds the fetch address

  typedef struct packed {
    logic [2:0] kind;
    addr_t      addr;
    strb_t      strb;
    data_t      data;
    data_t      exp;
  } step_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic flush, fetch_valid, fetch_lock, fetch_ready, fetch_rvalid;
  logic load_valid, load_rvalid, store_valid, store_done;
  fetch_req_t fetch_req;
  load_req_t  load_req;
  store_req_t store_req;
  data_t      fetch_rdata, load_rdata;
  logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
  logic w_valid, w_ready, b_valid, b_ready;
  axi_ar_t ar;
  axi_r_t  r;
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  logic [31:0] cycles;
  step_t       steps[$];

  always #5 clock = ~clock;

  // clocks since reset release
  always @(posedge clock) begin
    if (reset) cycles <= 0;
    else cycles <= cycles + 1;
  end

  core_bus UUT (.*);

  core_bus_mem_model mem (.*);

  always @(negedge clock) begin
    if (UUT.checker_inst.fail_count != 0) begin
      report_error("a bus protocol assertion failed");
    end
  end

  function automatic data_t preload_word(input addr_t a);
    return a[9:2] * 32'h0101_0101;
  endfunction

  task automatic add_step(input logic [2:0] k, input addr_t a, input strb_t s,
                          input data_t d, input data_t e);
    steps.push_back('{kind: k, addr: a, strb: s, data: d, exp: e});
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // AXI size is log2 of the bytes moved
  task automatic watch_ar(input string name, input logic on_bus, input strb_t s);
    size_t exp_size;
    exp_size = $clog2($countones(s));
    if (ar_valid && !on_bus) report_error({"timer load went out on AR in ", name});
    if (ar_valid && ar_ready) check_value({name, " ar size"}, exp_size, ar.size);
  endtask

  task automatic watch_write(input string name, input strb_t s);
    size_t exp_size;
    exp_size = $clog2($countones(s));
    if (aw_valid && aw_ready) check_value({name, " aw size"}, exp_size, aw.size);
    if (w_valid && w_ready) check_value({name, " w last"}, 1, w.last);
  endtask

  task automatic wait_load_rvalid(input string name, input logic on_bus, input strb_t s);
    int n;
    n = 0;
    @(negedge clock);
    watch_ar(name, on_bus, s);
    while (!load_rvalid) begin
      if (n == TIMEOUT) report_error({"timeout: no load response for ", name});
      n++;
      @(negedge clock);
      watch_ar(name, on_bus, s);
    end
  endtask

  task automatic fetch_word(input string name, input addr_t a, input data_t e);
    int n;
    @(posedge clock);
    #1 fetch_req = '{addr: a};
    fetch_valid = 1'b1;
    n = 0;
    @(negedge clock);
    check_value({name, " fetch_ready idle"}, 1, fetch_ready);
    watch_ar(name, 1'b1, 4'hf);
    while (!fetch_rvalid) begin
      if (n == TIMEOUT) report_error({"timeout: no fetch response for ", name});
      n++;
      @(negedge clock);
      watch_ar(name, 1'b1, 4'hf);
    end
    check_value(name, e, fetch_rdata);
    check_value({name, " fetch_ready busy"}, 0, fetch_ready);
    @(posedge clock);
    #1 fetch_valid = 1'b0;
  endtask

  task automatic load_lanes(input string name, input addr_t a, input strb_t s, input data_t e);
    @(posedge clock);
    #1 load_req = '{addr: a, strb: s};
    load_valid = 1'b1;
    wait_load_rvalid(name, 1'b1, s);
    check_value(name, e, load_rdata);
    @(posedge clock);
    #1 load_valid = 1'b0;
  endtask

  task automatic read_timer(input string name, input addr_t a, input data_t e);
    data_t expected;
    @(posedge clock);
    #1 load_req = '{addr: a, strb: 4'hf};
    load_valid = 1'b1;
    wait_load_rvalid(name, 1'b0, 4'hf);
    // granted one cycle before the response
    expected = (a == `CORE_BUS_MTIME_LO_ADDR) ? cycles - 1 : e;
    check_value(name, expected, load_rdata);
    @(posedge clock);
    #1 load_valid = 1'b0;
  endtask

  task automatic write_lanes(input string name, input addr_t a, input strb_t s, input data_t d);
    int n;
    @(posedge clock);
    #1 store_req = '{addr: a, data: d, strb: s};
    store_valid = 1'b1;
    n = 0;
    @(negedge clock);
    watch_write(name, s);
    while (!store_done) begin
      if (n == TIMEOUT) report_error({"timeout: store never completed for ", name});
      n++;
      @(negedge clock);
      watch_write(name, s);
    end
    @(posedge clock);
    #1 store_valid = 1'b0;
  endtask

  task automatic cancel_load(input string name, input addr_t a, input strb_t s);
    int n;
    @(posedge clock);
    #1 load_req = '{addr: a, strb: s};
    load_valid = 1'b1;
    n = 0;
    @(negedge clock);
    while (!(ar_valid && ar_ready)) begin
      if (n == TIMEOUT) report_error({"timeout: load address never accepted for ", name});
      n++;
      @(negedge clock);
    end
    @(posedge clock);
    #1 flush = 1'b1;
    load_valid = 1'b0;
    @(posedge clock);
    #1 flush = 1'b0;
    n = 0;
    @(negedge clock);
    while (!(r_valid && r_ready)) begin
      if (load_rvalid) report_error({"flushed load answered for ", name});
      if (n == TIMEOUT) report_error({"timeout: flushed read beat never came for ", name});
      n++;
      @(negedge clock);
    end
    if (load_rvalid) report_error({"flushed load answered for ", name});
  endtask

  task automatic race_fetch_load(input string name, input step_t st);
    int   n;
    logic fetch_seen;
    logic load_seen;
    @(posedge clock);
    #1 fetch_req = '{addr: st.data};
    load_req = '{addr: st.addr, strb: st.strb};
    fetch_valid = 1'b1;
    load_valid = 1'b1;
    fetch_seen = 1'b0;
    load_seen = 1'b0;
    n = 0;
    while (!load_seen) begin
      @(negedge clock);
      if (n == TIMEOUT) report_error({"timeout: fetch and load pair stuck in ", name});
      n++;
      if (load_rvalid) begin
        if (!fetch_seen) report_error({"load finished before the fetch in ", name});
        check_value({name, " load"}, st.exp, load_rdata);
        load_seen = 1'b1;
      end
      if (fetch_rvalid) begin
        check_value({name, " fetch"}, preload_word(st.data), fetch_rdata);
        fetch_seen = 1'b1;
        @(posedge clock);
        #1 fetch_valid = 1'b0;
      end
    end
    @(posedge clock);
    #1 load_valid = 1'b0;
  endtask

  initial begin
    string name;
    flush = 1'b0;
    fetch_valid = 1'b0;
    fetch_lock = 1'b0;
    fetch_req = '0;
    load_valid = 1'b0;
    load_req = '0;
    store_valid = 1'b0;
    store_req = '0;

    add_step(K_FETCH, 32'h004, 4'h0, 0, 32'h0101_0101);
    add_step(K_FETCH, 32'h3fc, 4'h0, 0, 32'hffff_ffff);
    add_step(K_LOAD,  32'h010, 4'h1, 0, 32'h0000_0004);
    add_step(K_LOAD,  32'h011, 4'h1, 0, 32'h0000_0004);
    add_step(K_LOAD,  32'h012, 4'h1, 0, 32'h0000_0004);
    add_step(K_LOAD,  32'h013, 4'h1, 0, 32'h0000_0004);
    add_step(K_LOAD,  32'h020, 4'h3, 0, 32'h0000_0808);
    add_step(K_LOAD,  32'h022, 4'h3, 0, 32'h0000_0808);
    add_step(K_STORE, 32'h041, 4'h1, 32'h0000_00ab, 0);
    add_step(K_STORE, 32'h082, 4'h3, 32'h0000_cdef, 0);
    add_step(K_STORE, 32'h0c3, 4'h1, 32'h0000_005a, 0);
    add_step(K_STORE, 32'h100, 4'hf, 32'h1234_5678, 0);
    add_step(K_LOAD,  32'h040, 4'hf, 0, 32'h1010_ab10);
    add_step(K_LOAD,  32'h080, 4'hf, 0, 32'hcdef_2020);
    add_step(K_LOAD,  32'h0c0, 4'hf, 0, 32'h5a30_3030);
    add_step(K_LOAD,  32'h041, 4'h1, 0, 32'h0000_00ab);
    add_step(K_LOAD,  32'h082, 4'h3, 0, 32'h0000_cdef);
    add_step(K_LOAD,  32'h102, 4'h3, 0, 32'h0000_1234);
    add_step(K_FLUSH, 32'h050, 4'hf, 0, 0);
    add_step(K_LOAD,  32'h054, 4'hf, 0, 32'h1515_1515);
    add_step(K_TIMER, `CORE_BUS_MTIME_LO_ADDR, 4'hf, 0, 0);
    add_step(K_TIMER, `CORE_BUS_MTIME_HI_ADDR, 4'hf, 0, 0);
    add_step(K_TIMER, `CORE_BUS_MTIME_LO_ADDR, 4'hf, 0, 0);
    add_step(K_BOTH,  32'h061, 4'h1, 32'h070, 32'h0000_0018);

    repeat (16) @(posedge clock);
    #1 reset = 1'b0;

    for (int i = 0; i < steps.size(); i++) begin
      name = $sformatf("step %0d", i);
      case (steps[i].kind)
        K_FETCH: fetch_word(name, steps[i].addr, steps[i].exp);
        K_LOAD:  load_lanes(name, steps[i].addr, steps[i].strb, steps[i].exp);
        K_STORE: write_lanes(name, steps[i].addr, steps[i].strb, steps[i].data);
        K_FLUSH: cancel_load(name, steps[i].addr, steps[i].strb);
        K_TIMER: read_timer(name, steps[i].addr, steps[i].exp);
        default: race_fetch_load(name, steps[i]);
      endcase
    end

    repeat (4) @(posedge clock);
    @(negedge clock);
    if (UUT.checker_inst.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- core_bus_timer.sv
`timescale 1ns/10ps

module core_bus_timer (
  input  logic                clock,
  input  logic                reset,
  input  logic                timer_req,
  input  logic                timer_sel_hi,
  output logic                timer_rvalid,
  output core_bus_pkg::data_t timer_rdata
);
  import core_bus_pkg::*;

  mtime_t mtime;
  data_t  word_sel;

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  assign word_sel = timer_sel_hi ? mtime[63:32] : mtime[31:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      timer_rvalid <= 1'b0;
    end else begin
      timer_rvalid <= timer_req;  // one cycle pulse
    end
  end

  // value as seen at the request edge
  always_ff @(posedge clock) begin
    if (timer_req) begin
      timer_rdata <= word_sel;
    end
  end

endmodule

//--- src.f
+incdir+.
core_bus_pkg.sv
core_bus_read_arbiter.sv
core_bus_store.sv
core_bus_timer.sv
core_bus_resp_router.sv
core_bus.sv
core_bus_mem_model.sv
core_bus_assertions.sv
core_bus_tb.sv
